/* src/exu_consts.svh */
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// datapath widths
`define EXU_XLEN    32
`define EXU_SHAMT_W 5
`define EXU_OP_W    6

// operation codes as delivered by the decode unit
`define EXU_OP_ADDI  6'd0
`define EXU_OP_LUI   6'd1
`define EXU_OP_AUIPC 6'd2
`define EXU_OP_JAL   6'd3
`define EXU_OP_JALR  6'd4
`define EXU_OP_ADD   6'd5
`define EXU_OP_BEQ   6'd6
`define EXU_OP_BNE   6'd7
`define EXU_OP_LW    6'd8
`define EXU_OP_SW    6'd9
`define EXU_OP_SEQZ  6'd10
`define EXU_OP_SUB   6'd12  // 11 was ebreak, unused here
`define EXU_OP_SLL   6'd13
`define EXU_OP_XORI  6'd14
`define EXU_OP_ZEXTB 6'd15
`define EXU_OP_AND   6'd16
`define EXU_OP_SRAI  6'd17
`define EXU_OP_SNEZ  6'd18
`define EXU_OP_ANDI  6'd19
`define EXU_OP_OR    6'd20
`define EXU_OP_BGE   6'd21
`define EXU_OP_SRLI  6'd22
`define EXU_OP_XOR   6'd23
`define EXU_OP_LBU   6'd24
`define EXU_OP_SLLI  6'd25
`define EXU_OP_BGEU  6'd26
`define EXU_OP_BLTU  6'd27
`define EXU_OP_SLTU  6'd28
`define EXU_OP_SLT   6'd29
`define EXU_OP_BLT   6'd30
`define EXU_OP_LH    6'd31
`define EXU_OP_LHU   6'd32
`define EXU_OP_SRA   6'd33
`define EXU_OP_SRL   6'd34
`define EXU_OP_SB    6'd35
`define EXU_OP_LB    6'd36
`define EXU_OP_ORI   6'd37
`define EXU_OP_SLTI  6'd38
`define EXU_OP_CSRRW 6'd48
`define EXU_OP_CSRRS 6'd49
`define EXU_OP_SH    6'd52

// sequential pc increment
`define EXU_PC_STEP 4

// store byte lanes
`define EXU_MASK_B 4'b0001
`define EXU_MASK_H 4'b0011
`define EXU_MASK_W 4'b1111

`endif

/* src/exu_pkg.sv */
`default_nettype none

package exu_pkg;

  // which outputs an instruction needs
  typedef enum logic [2:0] {
    cls_alu,     // rd and pc
    cls_jump,    // rd and pc
    cls_branch,  // pc only
    cls_load,    // mem, then rd and pc
    cls_store,   // mem, then pc
    cls_csr,     // rd, pc and csr
    cls_none     // unknown code
  } op_class_e;

  typedef enum logic [4:0] {
    fn_add,
    fn_sub,
    fn_and,
    fn_or,
    fn_xor,
    fn_sll,
    fn_srl,
    fn_sra,
    fn_slt,
    fn_sltu,
    fn_seqz,
    fn_snez,
    fn_zextb,
    fn_pass_b,   // lui
    fn_auipc,    // pc + imm, also branch and jal targets
    fn_csr_set   // csr | rs1
  } alu_fn_e;

  typedef enum logic [2:0] {
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_ltu,
    br_geu
  } br_cond_e;

  typedef enum logic [2:0] {
    ld_bs,  // byte, sign extended
    ld_bu,
    ld_hs,
    ld_hu,
    ld_w
  } ld_kind_e;

  typedef enum logic {
    opb_rs2,
    opb_imm
  } op_b_sel_e;

endpackage

`default_nettype wire

/* src/exu_decode.sv */
`default_nettype none
`include "exu_consts.svh"

module exu_decode import exu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 accept,
  input  logic [`EXU_XLEN-1:0] pc,
  input  logic [`EXU_XLEN-1:0] rs1_data,
  input  logic [`EXU_XLEN-1:0] rs2_data,
  input  logic [`EXU_XLEN-1:0] imm,
  input  logic [`EXU_XLEN-1:0] csr_rdata,
  input  logic [`EXU_OP_W-1:0] alu_op,
  output logic [`EXU_XLEN-1:0] pc_q,
  output logic [`EXU_XLEN-1:0] rs1_q,
  output logic [`EXU_XLEN-1:0] rs2_q,
  output logic [`EXU_XLEN-1:0] imm_q,
  output logic [`EXU_XLEN-1:0] csr_q,
  output op_class_e            op_class,
  output alu_fn_e              alu_fn,
  output op_b_sel_e            op_b_sel,
  output br_cond_e             br_cond,
  output ld_kind_e             ld_kind,
  output logic [3:0]           st_mask
);

  op_class_e  class_c, class_q;
  alu_fn_e    fn_c;
  op_b_sel_e  opb_c;
  br_cond_e   br_c;
  ld_kind_e   ld_c;
  logic [3:0] mask_c;

  always_comb begin
    case (alu_op)
      `EXU_OP_JAL, `EXU_OP_JALR: class_c = cls_jump;
      `EXU_OP_BEQ, `EXU_OP_BNE, `EXU_OP_BLT, `EXU_OP_BGE,
      `EXU_OP_BLTU, `EXU_OP_BGEU: class_c = cls_branch;
      `EXU_OP_LB, `EXU_OP_LBU, `EXU_OP_LH, `EXU_OP_LHU, `EXU_OP_LW: class_c = cls_load;
      `EXU_OP_SB, `EXU_OP_SH, `EXU_OP_SW: class_c = cls_store;
      `EXU_OP_CSRRW, `EXU_OP_CSRRS: class_c = cls_csr;
      `EXU_OP_ADDI, `EXU_OP_LUI, `EXU_OP_AUIPC, `EXU_OP_ADD, `EXU_OP_SUB,
      `EXU_OP_SEQZ, `EXU_OP_SNEZ, `EXU_OP_ZEXTB, `EXU_OP_AND, `EXU_OP_ANDI,
      `EXU_OP_OR, `EXU_OP_ORI, `EXU_OP_XOR, `EXU_OP_XORI, `EXU_OP_SLL,
      `EXU_OP_SLLI, `EXU_OP_SRL, `EXU_OP_SRLI, `EXU_OP_SRA, `EXU_OP_SRAI,
      `EXU_OP_SLT, `EXU_OP_SLTI, `EXU_OP_SLTU: class_c = cls_alu;
      default: class_c = cls_none;
    endcase

    case (alu_op)
      `EXU_OP_LUI: fn_c = fn_pass_b;
      `EXU_OP_AUIPC, `EXU_OP_JAL, `EXU_OP_BEQ, `EXU_OP_BNE, `EXU_OP_BLT,
      `EXU_OP_BGE, `EXU_OP_BLTU, `EXU_OP_BGEU: fn_c = fn_auipc;  // pc + imm target
      `EXU_OP_SUB: fn_c = fn_sub;
      `EXU_OP_AND, `EXU_OP_ANDI: fn_c = fn_and;
      `EXU_OP_OR, `EXU_OP_ORI: fn_c = fn_or;
      `EXU_OP_XOR, `EXU_OP_XORI: fn_c = fn_xor;
      `EXU_OP_SLL, `EXU_OP_SLLI: fn_c = fn_sll;
      `EXU_OP_SRL, `EXU_OP_SRLI: fn_c = fn_srl;
      `EXU_OP_SRA, `EXU_OP_SRAI: fn_c = fn_sra;
      `EXU_OP_SLT, `EXU_OP_SLTI: fn_c = fn_slt;
      `EXU_OP_SLTU: fn_c = fn_sltu;
      `EXU_OP_SEQZ: fn_c = fn_seqz;
      `EXU_OP_SNEZ: fn_c = fn_snez;
      `EXU_OP_ZEXTB: fn_c = fn_zextb;
      `EXU_OP_CSRRS: fn_c = fn_csr_set;
      default: fn_c = fn_add;  // addi, add, jalr, loads, stores
    endcase

    case (alu_op)
      `EXU_OP_ADDI, `EXU_OP_LUI, `EXU_OP_JALR, `EXU_OP_XORI, `EXU_OP_ANDI,
      `EXU_OP_ORI, `EXU_OP_SLLI, `EXU_OP_SRLI, `EXU_OP_SRAI, `EXU_OP_SLTI,
      `EXU_OP_LB, `EXU_OP_LBU, `EXU_OP_LH, `EXU_OP_LHU, `EXU_OP_LW,
      `EXU_OP_SB, `EXU_OP_SH, `EXU_OP_SW: opb_c = opb_imm;
      default: opb_c = opb_rs2;
    endcase

    case (alu_op)
      `EXU_OP_BNE: br_c = br_ne;
      `EXU_OP_BLT: br_c = br_lt;
      `EXU_OP_BGE: br_c = br_ge;
      `EXU_OP_BLTU: br_c = br_ltu;
      `EXU_OP_BGEU: br_c = br_geu;
      default: br_c = br_eq;
    endcase

    case (alu_op)
      `EXU_OP_LB: ld_c = ld_bs;
      `EXU_OP_LBU: ld_c = ld_bu;
      `EXU_OP_LH: ld_c = ld_hs;
      `EXU_OP_LHU: ld_c = ld_hu;
      default: ld_c = ld_w;
    endcase

    case (alu_op)
      `EXU_OP_SB: mask_c = `EXU_MASK_B;
      `EXU_OP_SH: mask_c = `EXU_MASK_H;
      `EXU_OP_SW: mask_c = `EXU_MASK_W;
      default: mask_c = 4'b0000;
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pc_q  <= pc;
      rs1_q <= rs1_data;
      rs2_q <= rs2_data;
      imm_q <= imm;
      csr_q <= csr_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      class_q  <= cls_none;
      alu_fn   <= fn_add;
      op_b_sel <= opb_rs2;
      br_cond  <= br_eq;
      ld_kind  <= ld_w;
      st_mask  <= 4'b0000;
    end else if (accept) begin
      class_q  <= class_c;
      alu_fn   <= fn_c;
      op_b_sel <= opb_c;
      br_cond  <= br_c;
      ld_kind  <= ld_c;
      st_mask  <= mask_c;
    end
  end

  // class seen in the accepting cycle so the FSM can pick its first phase
  assign op_class = accept ? class_c : class_q;

  a_class_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(op_class));

endmodule

`default_nettype wire

/* src/exu_execute.sv */
`default_nettype none
`include "exu_consts.svh"

module exu_execute import exu_pkg::*; (
  input  logic [`EXU_XLEN-1:0] pc_q,
  input  logic [`EXU_XLEN-1:0] rs1_q,
  input  logic [`EXU_XLEN-1:0] rs2_q,
  input  logic [`EXU_XLEN-1:0] imm_q,
  input  logic [`EXU_XLEN-1:0] csr_q,
  input  alu_fn_e              alu_fn,
  input  op_b_sel_e            op_b_sel,
  input  br_cond_e             br_cond,
  input  op_class_e            op_class,
  output logic [`EXU_XLEN-1:0] alu_result,
  output logic [`EXU_XLEN-1:0] mem_addr_c,
  output logic [`EXU_XLEN-1:0] branch_pc,
  output logic [`EXU_XLEN-1:0] csr_wdata_c
);

  logic [`EXU_XLEN-1:0]    op_b;
  logic [`EXU_SHAMT_W-1:0] shamt;
  logic [`EXU_XLEN-1:0]    alu_raw;
  logic [`EXU_XLEN-1:0]    seq_pc;
  logic                    cmp_bit;
  logic                    taken;

  assign op_b   = (op_b_sel == opb_imm) ? imm_q : rs2_q;
  assign shamt  = op_b[`EXU_SHAMT_W-1:0];
  assign seq_pc = pc_q + `EXU_PC_STEP;

  always_comb begin
    cmp_bit = 1'b0;
    case (alu_fn)
      fn_add:     alu_raw = rs1_q + op_b;
      fn_sub:     alu_raw = rs1_q - op_b;
      fn_and:     alu_raw = rs1_q & op_b;
      fn_or:      alu_raw = rs1_q | op_b;
      fn_xor:     alu_raw = rs1_q ^ op_b;
      fn_sll:     alu_raw = rs1_q << shamt;
      fn_srl:     alu_raw = rs1_q >> shamt;
      fn_sra:     alu_raw = $signed(rs1_q) >>> shamt;
      fn_zextb:   alu_raw = {{(`EXU_XLEN-8){1'b0}}, rs1_q[7:0]};
      fn_pass_b:  alu_raw = op_b;
      fn_auipc:   alu_raw = pc_q + imm_q;
      fn_csr_set: alu_raw = csr_q | rs1_q;
      default: begin
        // single-bit results, zero extended
        case (alu_fn)
          fn_slt:  cmp_bit = $signed(rs1_q) < $signed(op_b);
          fn_sltu: cmp_bit = rs1_q < op_b;
          fn_seqz: cmp_bit = (rs1_q == '0);
          fn_snez: cmp_bit = (op_b != '0);  // snez reads rs2
          default: cmp_bit = 1'b0;
        endcase
        alu_raw = {{(`EXU_XLEN-1){1'b0}}, cmp_bit};
      end
    endcase
  end

  always_comb begin
    case (br_cond)
      br_eq:   taken = (rs1_q == rs2_q);
      br_ne:   taken = (rs1_q != rs2_q);
      br_lt:   taken = $signed(rs1_q) < $signed(rs2_q);
      br_ge:   taken = $signed(rs1_q) >= $signed(rs2_q);
      br_ltu:  taken = rs1_q < rs2_q;
      br_geu:  taken = rs1_q >= rs2_q;
      default: taken = 1'b0;
    endcase
  end

  // jumps write the link address
  assign alu_result = (op_class == cls_jump) ? seq_pc : alu_raw;

  // loads and stores decode to add with the immediate
  assign mem_addr_c = alu_raw;

  always_comb begin
    case (op_class)
      cls_branch: branch_pc = taken ? alu_raw : seq_pc;
      cls_jump:   branch_pc = {alu_raw[`EXU_XLEN-1:1], 1'b0};  // jal or jalr target
      default:    branch_pc = seq_pc;
    endcase
  end

  assign csr_wdata_c = (alu_fn == fn_csr_set) ? alu_raw : rs1_q;  // csrrs or csrrw

endmodule

`default_nettype wire

/* src/exu_result.sv */
`default_nettype none
`include "exu_consts.svh"

module exu_result import exu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 idu_valid,
  output logic                 idu_ready,
  input  op_class_e            op_class,
  input  ld_kind_e             ld_kind,
  input  logic [3:0]           st_mask,
  input  logic [`EXU_XLEN-1:0] alu_result,
  input  logic [`EXU_XLEN-1:0] mem_addr_c,
  input  logic [`EXU_XLEN-1:0] branch_pc,
  input  logic [`EXU_XLEN-1:0] csr_wdata_c,
  input  logic [`EXU_XLEN-1:0] rs2_q,
  input  logic [`EXU_XLEN-1:0] csr_q,
  output logic                 accept,
  output logic                 mem_valid,
  output logic                 mem_wen,
  output logic [`EXU_XLEN-1:0] mem_addr,
  output logic [`EXU_XLEN-1:0] mem_wdata,
  output logic [3:0]           mem_wmask,
  input  logic                 mem_ready,
  input  logic [`EXU_XLEN-1:0] mem_rdata,
  output logic                 rd_valid,
  output logic [`EXU_XLEN-1:0] rd_data,
  input  logic                 rd_ready,
  output logic                 pc_valid,
  output logic [`EXU_XLEN-1:0] next_pc,
  input  logic                 pc_ready,
  output logic                 csr_valid,
  output logic [`EXU_XLEN-1:0] csr_wdata,
  input  logic                 csr_ready
);

  typedef enum logic [1:0] {
    st_idle,
    st_mem,
    st_wb
  } state_e;

  state_e               state_q, state_d;
  logic                 need_rd, need_pc, need_csr;
  logic                 wb_done;
  logic [`EXU_XLEN-1:0] ld_ext;
  logic [`EXU_XLEN-1:0] ld_q;

  assign idu_ready = (state_q == st_idle);
  assign accept    = idu_valid && idu_ready;

  // outputs each class asks for
  assign need_rd  = op_class inside {cls_alu, cls_jump, cls_load, cls_csr};
  assign need_pc  = (op_class != cls_none);
  assign need_csr = (op_class == cls_csr);

  // all needed readies in the same cycle
  assign wb_done = (!need_rd || rd_ready) && (!need_pc || pc_ready)
                && (!need_csr || csr_ready);

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (accept) begin
          if (op_class inside {cls_load, cls_store})
            state_d = st_mem;
          else if (op_class != cls_none)
            state_d = st_wb;  // unknown codes stay idle
        end
      end
      st_mem: begin
        if (mem_ready)
          state_d = st_wb;
      end
      st_wb: begin
        if (wb_done)
          state_d = st_idle;
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst)
      state_q <= st_idle;
    else
      state_q <= state_d;
  end

  always_comb begin
    case (ld_kind)
      ld_bs:   ld_ext = {{(`EXU_XLEN-8){mem_rdata[7]}}, mem_rdata[7:0]};
      ld_bu:   ld_ext = {{(`EXU_XLEN-8){1'b0}}, mem_rdata[7:0]};
      ld_hs:   ld_ext = {{(`EXU_XLEN-16){mem_rdata[15]}}, mem_rdata[15:0]};
      ld_hu:   ld_ext = {{(`EXU_XLEN-16){1'b0}}, mem_rdata[15:0]};
      default: ld_ext = mem_rdata;
    endcase
  end

  // load data captured with the memory response
  always_ff @(posedge clk) begin
    if (state_q == st_mem && mem_ready)
      ld_q <= ld_ext;
  end

  assign mem_valid = (state_q == st_mem);
  assign mem_wen   = (op_class == cls_store);
  assign mem_addr  = mem_addr_c;
  assign mem_wdata = rs2_q;
  assign mem_wmask = st_mask;  // zero for loads

  assign rd_valid  = (state_q == st_wb) && need_rd;
  assign pc_valid  = (state_q == st_wb) && need_pc;
  assign csr_valid = (state_q == st_wb) && need_csr;

  always_comb begin
    case (op_class)
      cls_load: rd_data = ld_q;
      cls_csr:  rd_data = csr_q;  // old csr value goes to rd
      default:  rd_data = alu_result;
    endcase
  end

  assign next_pc   = branch_pc;
  assign csr_wdata = csr_wdata_c;

  // request held with stable payload until the memory takes it
  a_mem_hold: assert property (@(posedge clk) disable iff (rst)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wdata));

endmodule

`default_nettype wire

/* src/exu_top.sv */
`default_nettype none
`include "exu_consts.svh"

module exu_top import exu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 idu_valid,
  output logic                 idu_ready,
  input  logic [`EXU_XLEN-1:0] pc,
  input  logic [`EXU_XLEN-1:0] rs1_data,
  input  logic [`EXU_XLEN-1:0] rs2_data,
  input  logic [`EXU_XLEN-1:0] imm,
  input  logic [`EXU_OP_W-1:0] alu_op,
  input  logic [`EXU_XLEN-1:0] csr_rdata,
  output logic                 mem_valid,
  output logic [`EXU_XLEN-1:0] mem_addr,
  output logic                 mem_wen,
  output logic [`EXU_XLEN-1:0] mem_wdata,
  output logic [3:0]           mem_wmask,
  input  logic                 mem_ready,
  input  logic [`EXU_XLEN-1:0] mem_rdata,
  output logic                 rd_valid,
  output logic [`EXU_XLEN-1:0] rd_data,
  input  logic                 rd_ready,
  output logic                 pc_valid,
  output logic [`EXU_XLEN-1:0] next_pc,
  input  logic                 pc_ready,
  output logic                 csr_valid,
  output logic [`EXU_XLEN-1:0] csr_wdata,
  input  logic                 csr_ready
);

  logic                 accept;
  logic [`EXU_XLEN-1:0] pc_q, rs1_q, rs2_q, imm_q, csr_q;
  op_class_e            op_class;
  alu_fn_e              alu_fn;
  op_b_sel_e            op_b_sel;
  br_cond_e             br_cond;
  ld_kind_e             ld_kind;
  logic [3:0]           st_mask;
  logic [`EXU_XLEN-1:0] alu_result, mem_addr_c, branch_pc, csr_wdata_c;

  exu_decode u_decode (
    .clk, .rst, .accept,
    .pc, .rs1_data, .rs2_data, .imm, .csr_rdata, .alu_op,
    .pc_q, .rs1_q, .rs2_q, .imm_q, .csr_q,
    .op_class, .alu_fn, .op_b_sel, .br_cond, .ld_kind, .st_mask
  );

  exu_execute u_execute (
    .pc_q, .rs1_q, .rs2_q, .imm_q, .csr_q,
    .alu_fn, .op_b_sel, .br_cond, .op_class,
    .alu_result, .mem_addr_c, .branch_pc, .csr_wdata_c
  );

  exu_result u_result (
    .clk, .rst, .idu_valid, .idu_ready,
    .op_class, .ld_kind, .st_mask,
    .alu_result, .mem_addr_c, .branch_pc, .csr_wdata_c, .rs2_q, .csr_q,
    .accept,
    .mem_valid, .mem_wen, .mem_addr, .mem_wdata, .mem_wmask, .mem_ready, .mem_rdata,
    .rd_valid, .rd_data, .rd_ready,
    .pc_valid, .next_pc, .pc_ready,
    .csr_valid, .csr_wdata, .csr_ready
  );

endmodule

`default_nettype wire

/* dv/exu_tb.sv */
`default_nettype none
`include "exu_consts.svh"

module exu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [`EXU_OP_W-1:0] op;
    logic [`EXU_XLEN-1:0] pc, rs1, rs2, imm, csr, mrd;
    logic                 has_rd, has_pc, has_mem, has_csr;  // transfers the row expects
    logic [`EXU_XLEN-1:0] exp_rd, exp_pc, exp_addr, exp_wdata, exp_csr;
    logic                 exp_wen;
    logic [3:0]           exp_mask;
  } row_t;

  logic                 clk, rst;
  logic                 idu_valid, idu_ready;
  logic [`EXU_XLEN-1:0] pc, rs1_data, rs2_data, imm, csr_rdata;
  logic [`EXU_OP_W-1:0] alu_op;
  logic                 mem_valid, mem_wen, mem_ready;
  logic [`EXU_XLEN-1:0] mem_addr, mem_wdata, mem_rdata;
  logic [3:0]           mem_wmask;
  logic                 rd_valid, rd_ready, pc_valid, pc_ready, csr_valid, csr_ready;
  logic [`EXU_XLEN-1:0] rd_data, next_pc, csr_wdata;

  row_t  rows [0:63];
  string names [0:63];
  int    n_rows, n_pass, n_fail;
  int    test_errs;
  string cur_name;
  int    cycles, cycle_limit;
  logic [31:0] lfsr;

  exu_top dut (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // run limit, set once the table is built
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, %s never completed its transfers", cycles, cur_name);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic lfsr_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out)
      lfsr = lfsr ^ 32'h8020_0003;
    return out;
  endfunction

  // high three cycles in four on average
  function automatic logic rand_ready();
    logic a, b;
    a = lfsr_bit();
    b = lfsr_bit();
    return a | b;
  endfunction

  task automatic start_row(input string name, input logic [`EXU_OP_W-1:0] op,
                           input logic [`EXU_XLEN-1:0] pc_v, rs1_v, rs2_v, imm_v, exp_pc);
    names[n_rows]       = name;
    rows[n_rows]        = '0;
    rows[n_rows].op     = op;
    rows[n_rows].pc     = pc_v;
    rows[n_rows].rs1    = rs1_v;
    rows[n_rows].rs2    = rs2_v;
    rows[n_rows].imm    = imm_v;
    rows[n_rows].has_pc = 1'b1;
    rows[n_rows].exp_pc = exp_pc;
  endtask

  task automatic alu_row(input string name, input logic [`EXU_OP_W-1:0] op,
                         input logic [`EXU_XLEN-1:0] rs1_v, rs2_v, imm_v, exp_rd);
    start_row(name, op, 32'h8000_0000, rs1_v, rs2_v, imm_v, 32'h8000_0004);
    rows[n_rows].has_rd = 1'b1;
    rows[n_rows].exp_rd = exp_rd;
    n_rows++;
  endtask

  task automatic branch_row(input string name, input logic [`EXU_OP_W-1:0] op,
                            input logic [`EXU_XLEN-1:0] rs1_v, rs2_v, imm_v, exp_pc);
    start_row(name, op, 32'h0000_1000, rs1_v, rs2_v, imm_v, exp_pc);
    n_rows++;
  endtask

  task automatic jump_row(input string name, input logic [`EXU_OP_W-1:0] op,
                          input logic [`EXU_XLEN-1:0] rs1_v, imm_v, exp_pc);
    start_row(name, op, 32'h0000_2000, rs1_v, 32'h0, imm_v, exp_pc);
    rows[n_rows].has_rd = 1'b1;
    rows[n_rows].exp_rd = 32'h0000_2004;  // link address
    n_rows++;
  endtask

  task automatic load_row(input string name, input logic [`EXU_OP_W-1:0] op,
                          input logic [`EXU_XLEN-1:0] rs1_v, imm_v, mrd, exp_addr, exp_rd);
    start_row(name, op, 32'h0000_0400, rs1_v, 32'h5555_aaaa, imm_v, 32'h0000_0404);
    rows[n_rows].mrd      = mrd;
    rows[n_rows].has_mem  = 1'b1;
    rows[n_rows].exp_addr = exp_addr;
    rows[n_rows].has_rd   = 1'b1;
    rows[n_rows].exp_rd   = exp_rd;
    n_rows++;
  endtask

  task automatic store_row(input string name, input logic [`EXU_OP_W-1:0] op,
                           input logic [`EXU_XLEN-1:0] rs1_v, rs2_v, imm_v, exp_addr,
                           input logic [3:0] exp_mask);
    start_row(name, op, 32'h0000_0400, rs1_v, rs2_v, imm_v, 32'h0000_0404);
    rows[n_rows].has_mem   = 1'b1;
    rows[n_rows].exp_addr  = exp_addr;
    rows[n_rows].exp_wen   = 1'b1;
    rows[n_rows].exp_wdata = rs2_v;
    rows[n_rows].exp_mask  = exp_mask;
    n_rows++;
  endtask

  task automatic csr_row(input string name, input logic [`EXU_OP_W-1:0] op,
                         input logic [`EXU_XLEN-1:0] rs1_v, csr_v, exp_csr);
    start_row(name, op, 32'h0000_0500, rs1_v, 32'h0, 32'h0, 32'h0000_0504);
    rows[n_rows].csr     = csr_v;
    rows[n_rows].has_rd  = 1'b1;
    rows[n_rows].exp_rd  = csr_v;  // old csr value
    rows[n_rows].has_csr = 1'b1;
    rows[n_rows].exp_csr = exp_csr;
    n_rows++;
  endtask

  task automatic compare_value(input string sig, input logic [`EXU_XLEN-1:0] expected, actual);
    if (actual !== expected) begin
      $display("Fail %s: %s expected %h, actual %h", cur_name, sig, expected, actual);
      test_errs++;
    end
  endtask

  task automatic report_error(input string what);
    $display("%s: %s", cur_name, what);
    test_errs++;
  endtask

  task automatic run_test(input int i);
    row_t r;
    logic mem_done, done, finished;
    r         = rows[i];
    cur_name  = names[i];
    test_errs = 0;
    alu_op    = r.op;
    {pc, rs1_data, rs2_data, imm, csr_rdata} = {r.pc, r.rs1, r.rs2, r.imm, r.csr};
    mem_rdata = r.mrd;
    idu_valid = 1'b1;
    finished  = 1'b0;
    while (!finished) begin  // hold valid until taken
      @(negedge clk);
      finished = idu_ready;
      @(posedge clk);
      #1;
    end
    idu_valid = 1'b0;
    alu_op    = ~r.op;
    {pc, rs1_data, rs2_data, imm, csr_rdata} = ~{r.pc, r.rs1, r.rs2, r.imm, r.csr};
    mem_done = !r.has_mem;
    done     = !r.has_pc;  // unknown code expects no transfer
    finished = 1'b0;
    while (!finished) begin
      mem_ready = rand_ready();
      rd_ready  = rand_ready();
      pc_ready  = rand_ready();
      csr_ready = rand_ready();
      @(negedge clk);
      if (done || idu_ready) begin
        if (mem_valid || rd_valid || pc_valid || csr_valid)
          report_error("a valid is still high after the write-back completed");
        if (done && !idu_ready)
          report_error("idu_ready did not return after the write-back");
        if (!done && idu_ready)
          report_error("idu_ready rose before every transfer completed");
        finished = 1'b1;
      end else begin
        if (mem_valid !== !mem_done)
          report_error(mem_valid ? "unexpected memory request" : "memory request missing");
        if (rd_valid !== (mem_done && r.has_rd))
          report_error(rd_valid ? "unexpected rd_valid" : "rd_valid missing");
        if (pc_valid !== mem_done)
          report_error(pc_valid ? "unexpected pc_valid" : "pc_valid missing");
        if (csr_valid !== (mem_done && r.has_csr))
          report_error(csr_valid ? "unexpected csr_valid" : "csr_valid missing");
        if (!mem_done && mem_ready) begin
          compare_value("mem_addr", r.exp_addr, mem_addr);
          compare_value("mem_wen", r.exp_wen, mem_wen);
          compare_value("mem_wmask", r.exp_mask, mem_wmask);
          if (r.exp_wen)
            compare_value("mem_wdata", r.exp_wdata, mem_wdata);
          mem_done = 1'b1;
        end else if (mem_done && (!r.has_rd || rd_ready) && pc_ready
                     && (!r.has_csr || csr_ready)) begin
          if (r.has_rd)
            compare_value("rd_data", r.exp_rd, rd_data);
          compare_value("next_pc", r.exp_pc, next_pc);
          if (r.has_csr)
            compare_value("csr_wdata", r.exp_csr, csr_wdata);
          done = 1'b1;
        end
      end
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    lfsr        = 32'h59e4_5030;
    cycles      = 0;
    cycle_limit = 0;
    n_rows      = 0;
    n_pass      = 0;
    n_fail      = 0;
    cur_name    = "reset";
    rst         = 1'b1;
    idu_valid   = 1'b0;
    alu_op      = '0;
    {pc, rs1_data, rs2_data, imm, csr_rdata, mem_rdata} = '0;
    {mem_ready, rd_ready, pc_ready, csr_ready} = 4'b0000;

    alu_row("addi", `EXU_OP_ADDI, 32'h0000_0010, 32'h0, 32'hffff_fff0, 32'h0);
    alu_row("add", `EXU_OP_ADD, 32'h7fff_ffff, 32'h1, 32'h0, 32'h8000_0000);
    alu_row("sub", `EXU_OP_SUB, 32'h5, 32'h7, 32'h0, 32'hffff_fffe);
    alu_row("and", `EXU_OP_AND, 32'hf0f0_1234, 32'h0ff0_ff00, 32'h0, 32'h00f0_1200);
    alu_row("or", `EXU_OP_OR, 32'hf000_000f, 32'h0000_ff00, 32'h0, 32'hf000_ff0f);
    alu_row("xori", `EXU_OP_XORI, 32'h0000_ffff, 32'h0, 32'hffff_ffff, 32'hffff_0000);
    alu_row("sll", `EXU_OP_SLL, 32'h3, 32'h24, 32'h0, 32'h30);  // bit 5 of amount ignored
    alu_row("srl", `EXU_OP_SRL, 32'h8000_0000, 32'h1f, 32'h0, 32'h1);
    alu_row("sra", `EXU_OP_SRA, 32'h8000_0000, 32'h4, 32'h0, 32'hf800_0000);
    alu_row("srai", `EXU_OP_SRAI, 32'hffff_ff00, 32'h0, 32'h8, 32'hffff_ffff);
    alu_row("slt", `EXU_OP_SLT, 32'hffff_ffff, 32'h1, 32'hffff_fff0, 32'h1);
    alu_row("sltu", `EXU_OP_SLTU, 32'h1, 32'hffff_ffff, 32'h0, 32'h1);
    alu_row("slti", `EXU_OP_SLTI, 32'hffff_fff0, 32'hffff_ffe0, 32'hffff_fffb, 32'h1);
    alu_row("seqz", `EXU_OP_SEQZ, 32'h0, 32'h9, 32'h0, 32'h1);
    alu_row("snez", `EXU_OP_SNEZ, 32'h0, 32'h100, 32'h0, 32'h1);  // source is rs2
    alu_row("zext.b", `EXU_OP_ZEXTB, 32'h1234_56f8, 32'h0, 32'h0, 32'hf8);
    alu_row("lui", `EXU_OP_LUI, 32'h0000_0abc, 32'h0, 32'h1234_5000, 32'h1234_5000);
    alu_row("auipc", `EXU_OP_AUIPC, 32'h0, 32'h0, 32'h2000, 32'h8000_2000);
    branch_row("beq taken", `EXU_OP_BEQ, 32'h7, 32'h7, 32'h40, 32'h1040);
    branch_row("beq not taken", `EXU_OP_BEQ, 32'h7, 32'h8, 32'h40, 32'h1004);
    branch_row("bne taken", `EXU_OP_BNE, 32'h7, 32'h8, 32'h40, 32'h1040);
    branch_row("bne not taken", `EXU_OP_BNE, 32'h7, 32'h7, 32'h40, 32'h1004);
    branch_row("blt taken", `EXU_OP_BLT, 32'hffff_ffff, 32'h1, 32'hffff_fff0, 32'h0ff0);
    branch_row("blt not taken", `EXU_OP_BLT, 32'h1, 32'hffff_ffff, 32'h40, 32'h1004);
    branch_row("bge taken", `EXU_OP_BGE, 32'h1, 32'hffff_ffff, 32'h40, 32'h1040);
    branch_row("bge not taken", `EXU_OP_BGE, 32'hffff_ffff, 32'h1, 32'h40, 32'h1004);
    branch_row("bltu taken", `EXU_OP_BLTU, 32'h1, 32'hffff_ffff, 32'h40, 32'h1040);
    branch_row("bltu not taken", `EXU_OP_BLTU, 32'hffff_ffff, 32'h1, 32'h40, 32'h1004);
    branch_row("bgeu taken", `EXU_OP_BGEU, 32'hffff_ffff, 32'h1, 32'h40, 32'h1040);
    branch_row("bgeu not taken", `EXU_OP_BGEU, 32'h1, 32'hffff_ffff, 32'h40, 32'h1004);
    jump_row("jal", `EXU_OP_JAL, 32'h0, 32'h100, 32'h2100);
    jump_row("jalr", `EXU_OP_JALR, 32'h3001, 32'h10, 32'h3010);  // bit 0 cleared
    load_row("lb", `EXU_OP_LB, 32'h0001_0000, 32'h4, 32'h1234_8586, 32'h0001_0004, 32'hffff_ff86);
    load_row("lbu", `EXU_OP_LBU, 32'h0001_0000, 32'h4, 32'h1234_85f6, 32'h0001_0004, 32'hf6);
    load_row("lh", `EXU_OP_LH, 32'h0001_0000, 32'h8, 32'h1234_8586, 32'h0001_0008, 32'hffff_8586);
    load_row("lhu", `EXU_OP_LHU, 32'h0001_0000, 32'h8, 32'h1234_8586, 32'h0001_0008, 32'h8586);
    load_row("lw", `EXU_OP_LW, 32'h0001_0000, 32'hffff_fffc, 32'h1234_8586, 32'h0000_fffc,
             32'h1234_8586);
    store_row("sb", `EXU_OP_SB, 32'h0002_0000, 32'hcafe_babe, 32'h1, 32'h0002_0001, 4'b0001);
    store_row("sh", `EXU_OP_SH, 32'h0002_0000, 32'h1357_2468, 32'h2, 32'h0002_0002, 4'b0011);
    store_row("sw", `EXU_OP_SW, 32'h0002_0000, 32'h89ab_cdef, 32'hffff_fffc, 32'h0001_fffc,
              4'b1111);
    csr_row("csrrw", `EXU_OP_CSRRW, 32'h0000_1888, 32'h0000_0480, 32'h0000_1888);
    csr_row("csrrs", `EXU_OP_CSRRS, 32'h0000_0808, 32'h0000_1800, 32'h0000_1808);
    start_row("unknown op", 6'd11, 32'h0000_0600, 32'h1, 32'h2, 32'h3, 32'h0);
    rows[n_rows].has_pc = 1'b0;  // no outputs at all
    n_rows++;
    cycle_limit = n_rows * 64;

    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    if (!idu_ready || mem_valid || rd_valid || pc_valid || csr_valid) begin
      $display("outputs are not idle after reset");
      n_fail++;
    end
    @(posedge clk);
    #1;

    for (int i = 0; i < n_rows; i++) begin
      run_test(i);
      if (test_errs == 0) begin
        $display("%s: ok", names[i]);
        n_pass++;
      end else begin
        $display("%s: %0d errors", names[i], test_errs);
        n_fail++;
      end
    end
    $display("%0d tests passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+src
src/exu_pkg.sv
src/exu_decode.sv
src/exu_execute.sv
src/exu_result.sv
src/exu_top.sv
dv/exu_tb.sv

/* Bender.yml */
package:
  name: exu

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/exu_pkg.sv
      - src/exu_decode.sv
      - src/exu_execute.sv
      - src/exu_result.sv
      - src/exu_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/exu_tb.sv
